/* all.f */
source/hazardPkg.sv
source/regFile.sv
source/instrDecode.sv
source/stageTracker.sv
source/hazardDetect.sv
source/issueControl.sv
source/issueFront.sv
bench/issueFront_tb.sv

/* run.sh */
#!/bin/sh
# build and run the issueFront testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 --top-module issueFront_tb -f all.f -o simv > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* bench/issueFront_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module issueFront_tb
    import hazardPkg::*;
;

    localparam int numDirected = 12;
    localparam int numRandom   = 288;
    localparam int maxCycles   = (numDirected + numRandom) * 12 + 400;   // worst case per instr

    typedef struct packed {
        logic       take;
        logic       drop;
        logic       jump;
        issueT      iss;
        stageEntryT ent;
    } predT;

    logic    clk;
    logic    rst;
    logic    inReq;
    wordT    inInstr;
    logic    inAck;
    wbWriteT wbWrite;
    issueT   issueOut;

    // reference model state
    wordT                    mRegs [8];
    stageEntryT [STAGES-1:0] mTrk;       // 0 is ID
    logic                    mSquash;
    logic                    mAck;
    logic                    expAck;
    issueT                   expIssue;

    int seedVal;
    int cycleCount = 0;
    int errCount   = 0;
    int checkCount = 0;
    int sentCount  = 0;
    int dropCount  = 0;
    int stallCount = 0;
    int dutIssued  = 0;

    issueFront uut (
        .clk      (clk),
        .rst      (rst),
        .inReq    (inReq),
        .inInstr  (inInstr),
        .inAck    (inAck),
        .wbWrite  (wbWrite),
        .issueOut (issueOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic wordT encodeInstr(input opcodeT op, input regIdxT rs, input regIdxT rt,
                                         input logic [4:0] low);
        return {op, 2'b00, rs, rt, low};
    endfunction

    // expected decision and issue record for the current cycle
    function automatic predT predictIssue(input logic req, input wordT instr);
        predT   p;
        opcodeT op;
        regIdxT rs;
        regIdxT rt;
        wordT   addr;
        logic   wr;
        logic   mem;
        logic   hazard;
        op     = instr[15:13];
        rs     = instr[10:8];
        rt     = instr[7:5];
        wr     = (op == opAlu) || (op == opLoad) || (op == opAddi);
        mem    = (op == opLoad) || (op == opStore);
        addr   = mRegs[rs] + {{11{instr[4]}}, instr[4:0]};
        hazard = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            if (mTrk[i].valid && mTrk[i].writesReg && (mTrk[i].rd == rs || mTrk[i].rd == rt))
                hazard = 1'b1;
            if (mTrk[i].valid && mTrk[i].memEnable && mem && mTrk[i].memAddr == addr)
                hazard = 1'b1;
        end
        p      = '0;
        p.jump = (op == opJump) || (op == opBranch);
        p.take = req && !mAck && (mSquash || !hazard);   // squash wins over a stall
        p.drop = p.take && mSquash;
        if (p.take && !p.drop) begin
            p.iss.valid     = 1'b1;
            p.iss.instr     = instr;
            p.iss.rd        = instr[4:2];
            p.iss.writesReg = wr;
            p.iss.memEnable = mem;
            p.iss.memAddr   = addr;
            p.ent.valid     = 1'b1;
            p.ent.rd        = instr[4:2];
            p.ent.writesReg = wr;
            p.ent.memEnable = mem;
            p.ent.memAddr   = addr;
        end
        return p;
    endfunction

    // model steps on the same edge as the DUT
    always @(posedge clk) begin
        predT p;
        if (rst) begin
            for (int i = 0; i < 8; i++) mRegs[i] = '0;
            mTrk     = '0;
            mSquash  = 1'b0;
            mAck     = 1'b0;
            expAck   = 1'b0;
            expIssue = '0;
        end else begin
            p = predictIssue(inReq, inInstr);
            if (inReq && !mAck && !p.take) stallCount++;
            if (p.drop) dropCount++;
            if (mAck) begin
                if (!inReq) mAck = 1'b0;   // four-phase return
            end else if (p.take) begin
                mAck = 1'b1;
            end
            expAck   = mAck;
            expIssue = p.iss;
            mTrk     = {mTrk[STAGES-2:0], p.ent};
            if (p.take) mSquash = p.jump && !p.drop;
            if (wbWrite.en) mRegs[wbWrite.idx] = wbWrite.data;   // read sees old value this cycle
        end
    end

    task automatic reportMismatch(input string name, input logic [15:0] expVal,
                                  input logic [15:0] gotVal);
        errCount++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expVal, gotVal);
    endtask

    // registered outputs settle well before the falling edge
    always @(negedge clk) begin
        checkCount++;
        if (issueOut.valid === 1'b1) dutIssued++;
        if (inAck !== expAck) reportMismatch("inAck", 16'(expAck), 16'(inAck));
        if (issueOut.valid !== expIssue.valid) begin
            reportMismatch("issueOut.valid", 16'(expIssue.valid), 16'(issueOut.valid));
        end else if (expIssue.valid) begin
            if (issueOut.instr !== expIssue.instr)
                reportMismatch("issueOut.instr", expIssue.instr, issueOut.instr);
            if (issueOut.rd !== expIssue.rd)
                reportMismatch("issueOut.rd", 16'(expIssue.rd), 16'(issueOut.rd));
            if (issueOut.writesReg !== expIssue.writesReg)
                reportMismatch("issueOut.writesReg", 16'(expIssue.writesReg),
                               16'(issueOut.writesReg));
            if (issueOut.memEnable !== expIssue.memEnable)
                reportMismatch("issueOut.memEnable", 16'(expIssue.memEnable),
                               16'(issueOut.memEnable));
            if (issueOut.memAddr !== expIssue.memAddr)
                reportMismatch("issueOut.memAddr", expIssue.memAddr, issueOut.memAddr);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("timeout after %0d cycles, the handshake stopped making progress", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    // starts and ends on a falling edge
    task automatic writeReg(input regIdxT idx, input wordT data);
        wbWrite.en   = 1'b1;
        wbWrite.idx  = idx;
        wbWrite.data = data;
        @(negedge clk);
        wbWrite = '0;
    endtask

    task automatic sendInstr(input wordT instr, input int maxGap);
        int gap;
        inInstr = instr;
        inReq   = 1'b1;
        do @(negedge clk); while (!inAck);
        inReq = 1'b0;
        do @(negedge clk); while (inAck);
        sentCount++;
        gap = int'($urandom_range(0, maxGap));
        repeat (gap) begin
            if ($urandom_range(0, 3) == 0) begin   // occasional write-back between requests
                writeReg(regIdxT'($urandom_range(0, 7)), wordT'($urandom_range(0, 7)));
            end else begin
                @(negedge clk);
            end
        end
    endtask

    initial begin
        seedVal = $urandom(90);
        rst     = 1'b1;
        inReq   = 1'b0;
        inInstr = '0;
        wbWrite = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 1; i < 8; i++) writeReg(regIdxT'(i), wordT'(16'h0040 * i + 16'h0003));

        // back to back so every hazard falls inside the tracker window
        sendInstr(encodeInstr(opAddi, 3'd0, 3'd0, 5'b00100), 0);    // writes r1
        sendInstr(encodeInstr(opAlu, 3'd1, 3'd2, 5'b01100), 0);     // reads r1 and stalls
        sendInstr(encodeInstr(opLoad, 3'd2, 3'd0, 5'b10011), 0);    // negative offset
        sendInstr(encodeInstr(opStore, 3'd2, 3'd0, 5'b10011), 0);   // same address so it stalls
        sendInstr(encodeInstr(opStore, 3'd5, 3'd0, 5'b00001), 0);   // other address
        sendInstr(encodeInstr(opJump, 3'd0, 3'd0, 5'b00000), 0);
        sendInstr(encodeInstr(opAlu, 3'd0, 3'd0, 5'b11000), 0);     // squashed although it writes r6
        sendInstr(encodeInstr(opAlu, 3'd6, 3'd0, 5'b00100), 0);     // no hazard on dropped r6
        sendInstr(encodeInstr(opAddi, 3'd0, 3'd0, 5'b11100), 0);    // writes r7
        sendInstr(encodeInstr(opBranch, 3'd0, 3'd0, 5'b00000), 0);
        sendInstr(encodeInstr(opAlu, 3'd7, 3'd0, 5'b00000), 0);     // hazard but squashed
        sendInstr(encodeInstr(opNop, 3'd0, 3'd0, 5'b00000), 0);

        for (int n = 0; n < numRandom; n++) sendInstr(wordT'($urandom), 2);

        repeat (3) @(posedge clk);
        if (dutIssued != sentCount - dropCount) begin
            errCount++;
            $display("issue count wrong, %0d requests with %0d squashed gave %0d issues",
                     sentCount, dropCount, dutIssued);
        end
        $display("checks=%0d errors=%0d requests=%0d issued=%0d squashed=%0d stalls=%0d",
                 checkCount, errCount, sentCount, dutIssued, dropCount, stallCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/issueFront.sv */
`timescale 1ns/1ps
`default_nettype none

module issueFront
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inReq,
    input  wordT    inInstr,
    output logic    inAck,
    input  wbWriteT wbWrite,
    output issueT   issueOut
);

    regIdxT                  rsIdx;
    wordT                    baseData;
    decodedT                 dec;
    stageEntryT              insert;
    stageEntryT [STAGES-1:0] stages;
    logic                    pending;
    logic                    take;
    logic                    drop;

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdIdx   (rsIdx),
        .rdData  (baseData),
        .wbWrite (wbWrite)
    );

    instrDecode u_instrDecode (
        .instr    (inInstr),
        .baseData (baseData),
        .rsIdx    (rsIdx),
        .dec      (dec)
    );

    stageTracker u_stageTracker (
        .clk    (clk),
        .rst    (rst),
        .insert (insert),
        .stages (stages)
    );

    hazardDetect u_hazardDetect (
        .clk     (clk),
        .rst     (rst),
        .pending (pending),
        .dec     (dec),
        .stages  (stages),
        .take    (take),
        .drop    (drop)
    );

    issueControl u_issueControl (
        .clk      (clk),
        .rst      (rst),
        .inReq    (inReq),
        .inAck    (inAck),
        .pending  (pending),
        .take     (take),
        .drop     (drop),
        .dec      (dec),
        .instr    (inInstr),
        .insert   (insert),
        .issueOut (issueOut)
    );

endmodule

`default_nettype wire

/* source/issueControl.sv */
`timescale 1ns/1ps
`default_nettype none

module issueControl
    import hazardPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inReq,
    output logic       inAck,
    output logic       pending,
    input  logic       take,
    input  logic       drop,
    input  decodedT    dec,
    input  wordT       instr,
    output stageEntryT insert,
    output issueT      issueOut
);

    ackStateT state;
    ackStateT stateNext;
    logic     issueNow;

    assign issueNow = take && !drop;

    // four-phase handshake
    always_comb begin
        stateNext = state;
        case (state)
            ackIdle: if (take) stateNext = ackHigh;       // ack once consumed
            ackHigh: if (!inReq) stateNext = ackIdle;     // wait for req to drop
            default: stateNext = ackIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ackIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign inAck   = (state == ackHigh);
    assign pending = inReq && (state == ackIdle);

    // one-cycle issue pulse, payload held until the next issue
    always_ff @(posedge clk) begin
        if (rst) begin
            issueOut.valid <= 1'b0;
        end else begin
            issueOut.valid <= issueNow;
        end
        if (issueNow) begin
            issueOut.instr     <= instr;
            issueOut.rd        <= dec.rd;
            issueOut.writesReg <= dec.writesReg;
            issueOut.memEnable <= dec.memEnable;
            issueOut.memAddr   <= dec.memAddr;
        end
    end

    // bubble on stall or squash
    always_comb begin
        insert = '0;
        if (issueNow) begin
            insert.valid     = 1'b1;
            insert.rd        = dec.rd;
            insert.writesReg = dec.writesReg;
            insert.memEnable = dec.memEnable;
            insert.memAddr   = dec.memAddr;
        end
    end

endmodule

`default_nettype wire

/* source/hazardDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardDetect
    import hazardPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pending,
    input  decodedT                 dec,
    input  stageEntryT [STAGES-1:0] stages,
    output logic                    take,
    output logic                    drop
);

    logic [STAGES-1:0] regHit;
    logic [STAGES-1:0] memHit;
    logic              regHazard;
    logic              memHazard;
    logic              squash;   // last taken instruction was a jump or branch

    // per-stage comparisons
    always_comb begin
        for (int i = 0; i < STAGES; i++) begin
            regHit[i] = stages[i].valid && stages[i].writesReg &&
                        ((stages[i].rd == dec.rs) || (stages[i].rd == dec.rt));

            // both sides must touch memory
            memHit[i] = stages[i].valid && stages[i].memEnable && dec.memEnable &&
                        (stages[i].memAddr == dec.memAddr);
        end
    end

    assign regHazard = |regHit;
    assign memHazard = |memHit;

    // a squashed slot is consumed whatever its hazards
    assign take = pending && (squash || !(regHazard || memHazard));
    assign drop = take && squash;

    always_ff @(posedge clk) begin
        if (rst) begin
            squash <= 1'b0;
        end else if (take) begin
            squash <= !drop && dec.isJump;   // a dropped jump arms nothing
        end
    end

endmodule

`default_nettype wire

/* source/stageTracker.sv */
`timescale 1ns/1ps
`default_nettype none

module stageTracker
    import hazardPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  stageEntryT              insert,   // issued record or bubble
    output stageEntryT [STAGES-1:0] stages    // 0 is ID, STAGES-1 is WB
);

    stageEntryT [STAGES-1:0] pipe;

    // one step older every clock, no hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe <= '0;
        end else begin
            pipe <= {pipe[STAGES-2:0], insert};
        end
    end

    assign stages = pipe;

endmodule

`default_nettype wire

/* source/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode
    import hazardPkg::*;
(
    input  wordT    instr,
    input  wordT    baseData,   // register file value of rs
    output regIdxT  rsIdx,
    output decodedT dec
);

    opcodeT opcode;
    wordT   immExt;
    logic   writesReg;
    logic   memEnable;
    logic   isJump;

    assign opcode = instr[opcodeMsb:opcodeLsb];
    assign rsIdx  = instr[rsMsb:rsLsb];

    // sign-extend the 5-bit offset
    assign immExt = {{(wordW - (immMsb - immLsb + 1)){instr[immMsb]}},
                     instr[immMsb:immLsb]};

    always_comb begin
        writesReg = 1'b0;
        memEnable = 1'b0;
        isJump    = 1'b0;
        case (opcode)
            opAlu, opAddi: begin
                writesReg = 1'b1;
            end
            opLoad: begin
                writesReg = 1'b1;
                memEnable = 1'b1;
            end
            opStore: begin
                memEnable = 1'b1;
            end
            opJump, opBranch: begin
                isJump = 1'b1;   // next instruction gets squashed
            end
            opNop, opRsvd: begin
                writesReg = 1'b0;
            end
            default: begin
                writesReg = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec.rs        = instr[rsMsb:rsLsb];
        dec.rt        = instr[rtMsb:rtLsb];
        dec.rd        = instr[rdMsb:rdLsb];
        dec.writesReg = writesReg;
        dec.memEnable = memEnable;
        dec.isJump    = isJump;
        dec.memAddr   = baseData + immExt;   // formed for every opcode, used only with memEnable
    end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regIdxT  rdIdx,
    output wordT    rdData,
    input  wbWriteT wbWrite
);

    wordT regs [numRegs];

    // write-back port, registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite.en) begin
            regs[wbWrite.idx] <= wbWrite.data;
        end
    end

    // no bypass, a same-cycle write shows up on the next read
    assign rdData = regs[rdIdx];

endmodule

`default_nettype wire

/* source/hazardPkg.sv */
`default_nettype none

package hazardPkg;

    // widths
    localparam int wordW   = 16;
    localparam int regIdxW = 3;
    localparam int opcodeW = 3;
    localparam int numRegs = 8;
    localparam int STAGES  = 4;   // ID, EX, MEM, WB

    typedef logic [wordW-1:0]   wordT;
    typedef logic [regIdxW-1:0] regIdxT;
    typedef logic [opcodeW-1:0] opcodeT;

    // instruction field positions
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 13;
    localparam int rsMsb     = 10;
    localparam int rsLsb     = 8;
    localparam int rtMsb     = 7;
    localparam int rtLsb     = 5;
    localparam int rdMsb     = 4;
    localparam int rdLsb     = 2;
    localparam int immMsb    = 4;   // overlaps rd, only loads/stores read it as an offset
    localparam int immLsb    = 0;

    // opcode classes
    localparam opcodeT opNop    = 3'b000;
    localparam opcodeT opJump   = 3'b001;
    localparam opcodeT opAlu    = 3'b010;
    localparam opcodeT opBranch = 3'b011;
    localparam opcodeT opLoad   = 3'b100;
    localparam opcodeT opStore  = 3'b101;
    localparam opcodeT opAddi   = 3'b110;
    localparam opcodeT opRsvd   = 3'b111;   // behaves as nop

    typedef struct packed {
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
        logic   writesReg;
        logic   memEnable;
        logic   isJump;      // jump or branch
        wordT   memAddr;
    } decodedT;

    // what the tracker remembers about each issued slot
    typedef struct packed {
        logic   valid;
        regIdxT rd;
        logic   writesReg;
        logic   memEnable;
        wordT   memAddr;
    } stageEntryT;

    typedef struct packed {
        logic   valid;
        wordT   instr;
        regIdxT rd;
        logic   writesReg;
        logic   memEnable;
        wordT   memAddr;
    } issueT;

    typedef struct packed {
        logic   en;
        regIdxT idx;
        wordT   data;
    } wbWriteT;

    typedef enum logic {
        ackIdle,
        ackHigh
    } ackStateT;

endpackage

`default_nettype wire
